/* ft_test_ctrl.f */
rtl/ft_test_pkg.sv
rtl/rx_packet_parser.sv
rtl/test_sequencer.sv
rtl/response_writer.sv
rtl/ft_test_ctrl.sv
test/ft_test_ctrl_properties.sv
test/ft_test_ctrl_tb.sv

/* test/ft_test_ctrl_tb.sv */
// ========================================
// FT test controller testbench
// FIFO models around the DUT and a table
// of packet scenarios with expected replies
// ========================================
`timescale 1ns/1ps

module ft_test_ctrl_tb;
    import ft_test_pkg::*;

    logic  clk;
    logic  reset_i;
    logic  rd_empty_i;
    byte_t rd_data_i;
    logic  rd_en_o;
    logic  wr_full_i;
    logic  wr_afull_i;
    logic  wr_en_o;
    byte_t wr_data_o;
    logic  err_o;

    // Input FIFO contents and read pointer
    byte_t in_mem [10];
    int    in_count;
    int    rd_idx;
    // Bytes written by the DUT
    byte_t out_q [$];
    logic [31:0] lcg_state;

    // Scenario table
    byte_t in_tab [7][10];
    byte_t exp_tab [7][10];
    int    in_n [7];
    int    rd_n [7];
    int    exp_n [7];
    logic  err_tab [7];

    ft_test_ctrl u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_empty_i (rd_empty_i),
        .rd_data_i  (rd_data_i),
        .rd_en_o    (rd_en_o),
        .wr_full_i  (wr_full_i),
        .wr_afull_i (wr_afull_i),
        .wr_en_o    (wr_en_o),
        .wr_data_o  (wr_data_o),
        .err_o      (err_o)
    );

    bind ft_test_ctrl ft_test_ctrl_properties u_props (.*);

    always #10 clk = ~clk;

    // ========================================
    // FIFO models
    // ========================================
    // FWFT input FIFO pops on edges with rd_en_o high
    always @(posedge clk) begin : input_fifo
        int nxt;
        if (reset_i) begin
            nxt = 0;
        end else if (rd_en_o) begin
            nxt = rd_idx + 1;
        end else begin
            nxt = rd_idx;
        end
        rd_idx     <= nxt;
        rd_empty_i <= (nxt >= in_count);
        rd_data_i  <= in_mem[nxt];
    end

    // Write strobe and data held over the whole cycle
    always @(negedge clk) begin
        if (wr_en_o) begin
            out_q.push_back(wr_data_o);
        end
    end

    // Random almost-full in about one cycle of four
    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        wr_afull_i <= (lcg_state[31:30] == 2'b00);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Command in bits 7..6 and length in bits 5..0
    function automatic byte_t header_byte(input cmd_t cmd, input len_t len);
        return {cmd, len};
    endfunction

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic set_counts(input int r, input int n_in, input int n_rd,
                              input int n_exp, input logic err);
        in_n[r]    = n_in;
        rd_n[r]    = n_rd;
        exp_n[r]   = n_exp;
        err_tab[r] = err;
    endtask

    // ========================================
    // Scenario table
    // ========================================
    task automatic load_table();
        // Clean receive test run
        in_tab[0]  = '{header_byte(CMD_START, 1), TEST_RECEIVE, header_byte(CMD_DATA, 5),
                       0, 1, 2, 3, 4, header_byte(CMD_STOP, 0), 0};
        exp_tab[0] = '{header_byte(CMD_STOPPED, 1), ERR_NONE, 0, 0, 0, 0, 0, 0, 0, 0};
        set_counts(0, 9, 9, 2, 1'b0);
        // Loopback gives one echo packet per good byte
        in_tab[1]  = '{header_byte(CMD_START, 1), TEST_LOOPBACK, header_byte(CMD_DATA, 3),
                       0, 1, 2, header_byte(CMD_STOP, 0), 0, 0, 0};
        exp_tab[1] = '{header_byte(CMD_DATA, 1), 0, header_byte(CMD_DATA, 1), 1,
                       header_byte(CMD_DATA, 1), 2, header_byte(CMD_STOPPED, 1),
                       ERR_NONE, 0, 0};
        set_counts(1, 7, 7, 8, 1'b0);
        // Wrong data leaves the trailing bytes unread
        in_tab[2]  = '{header_byte(CMD_START, 1), TEST_RECEIVE, header_byte(CMD_DATA, 3),
                       0, 1, 7, header_byte(CMD_STOP, 0), header_byte(CMD_DATA, 1), 8, 0};
        exp_tab[2] = '{header_byte(CMD_STOPPED, 3), ERR_TEST_DATA, 7, 2, 0, 0, 0, 0, 0, 0};
        set_counts(2, 9, 6, 4, 1'b1);
        // Test number 2 is invalid
        in_tab[3]  = '{header_byte(CMD_START, 1), 2, header_byte(CMD_STOP, 0),
                       0, 0, 0, 0, 0, 0, 0};
        exp_tab[3] = '{header_byte(CMD_STOPPED, 2), ERR_TEST_NUM, 2, 0, 0, 0, 0, 0, 0, 0};
        set_counts(3, 3, 2, 3, 1'b1);
        // Header errors stop at the header byte
        in_tab[4]  = '{header_byte(CMD_START, 2), 0, 0, header_byte(CMD_STOP, 0),
                       0, 0, 0, 0, 0, 0};
        exp_tab[4] = '{header_byte(CMD_STOPPED, 1), ERR_START_PAYLOAD, 0, 0, 0, 0, 0, 0, 0, 0};
        set_counts(4, 4, 1, 2, 1'b1);
        in_tab[5]  = '{header_byte(CMD_STOP, 1), 0, header_byte(CMD_STOP, 0),
                       0, 0, 0, 0, 0, 0, 0};
        exp_tab[5] = '{header_byte(CMD_STOPPED, 1), ERR_STOP_PAYLOAD, 0, 0, 0, 0, 0, 0, 0, 0};
        set_counts(5, 3, 1, 2, 1'b1);
        in_tab[6]  = '{header_byte(CMD_STOPPED, 0), header_byte(CMD_STOP, 0),
                       0, 0, 0, 0, 0, 0, 0, 0};
        exp_tab[6] = '{header_byte(CMD_STOPPED, 1), ERR_INVALID_CMD, 0, 0, 0, 0, 0, 0, 0, 0};
        set_counts(6, 2, 1, 2, 1'b1);
    endtask

    // Reset, load the input FIFO, wait for the reply and compare
    task automatic run_scenario(input int r);
        int i;
        int cycles;
        @(posedge clk);
        reset_i <= 1'b1;
        in_count = in_n[r];
        for (i = 0; i < 10; i++) begin
            in_mem[i] = in_tab[r][i];
        end
        out_q.delete();
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        cycles = 0;
        while (out_q.size() < exp_n[r] && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (out_q.size() < exp_n[r]) begin
            $display("Timeout in scenario %0d: %0d of %0d reply bytes after %0d cycles",
                     r, out_q.size(), exp_n[r], cycles);
            stop_on_failure();
        end
        // Nothing more may appear in the quiet period
        repeat (20) @(posedge clk);
        check_value($sformatf("scenario %0d reply length", r), out_q.size(), exp_n[r]);
        for (i = 0; i < exp_n[r]; i++) begin
            check_value($sformatf("scenario %0d reply byte %0d", r, i), out_q[i],
                        exp_tab[r][i]);
        end
        check_value($sformatf("scenario %0d err_o", r), err_o, err_tab[r]);
        check_value($sformatf("scenario %0d bytes read", r), rd_idx, rd_n[r]);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin : main_sequence
        int r;
        clk        = 1'b0;
        reset_i    = 1'b1;
        rd_empty_i = 1'b1;
        rd_data_i  = '0;
        wr_full_i  = 1'b0;
        wr_afull_i = 1'b0;
        lcg_state  = 32'h579ba878;
        rd_idx     = 0;
        in_count   = 0;
        load_table();
        for (r = 0; r < $size(in_n); r++) begin
            run_scenario(r);
        end
        if (u_dut.u_props.assert_failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", u_dut.u_props.assert_failures);
            stop_on_failure();
        end
    end

endmodule

/* test/ft_test_ctrl_properties.sv */
// ========================================
// FT test controller properties
// FIFO enable rules and halt behavior,
// bound onto the top level
// ========================================
`timescale 1ns/1ps

module ft_test_ctrl_properties (
    input logic clk,
    input logic reset_i,
    input logic rd_empty_i,
    input logic rd_en_o,
    input logic wr_full_i,
    input logic wr_afull_i,
    input logic wr_en_o,
    input logic err_o
);

    // Failure count, read by the testbench at the end
    int assert_failures = 0;

    // Never read an empty FIFO
    a_read_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        rd_en_o |-> !rd_empty_i)
        else begin
            assert_failures++;
            $error("rd_en_o high while the input FIFO is empty");
        end

    // Write only when the flags showed room at the previous edge
    a_write_has_room: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_o |-> $past(!wr_afull_i && !wr_full_i))
        else begin
            assert_failures++;
            $error("wr_en_o high without room in the output FIFO");
        end

    // Halted after a failure, no more input reads
    a_halt_no_read: assert property (@(posedge clk) disable iff (reset_i)
        err_o |-> !rd_en_o)
        else begin
            assert_failures++;
            $error("Input read while err_o is high");
        end

    // Error flag holds until reset
    a_err_holds: assert property (@(posedge clk) disable iff (reset_i)
        err_o |=> err_o)
        else begin
            assert_failures++;
            $error("err_o dropped without a reset");
        end

endmodule

/* rtl/ft_test_ctrl.sv */
// ========================================
// FT bridge test controller, top level
// Parser, test sequencer and response
// writer between the two FIFOs
// ========================================
`timescale 1ns/1ps

module ft_test_ctrl (
    input  logic               clk,
    input  logic               reset_i,
    // Input FIFO, first word fall-through
    input  logic               rd_empty_i,
    input  ft_test_pkg::byte_t rd_data_i,
    output logic               rd_en_o,
    // Output FIFO
    input  logic               wr_full_i,
    input  logic               wr_afull_i,
    output logic               wr_en_o,
    output ft_test_pkg::byte_t wr_data_o,
    // Test failure flag
    output logic               err_o
);
    import ft_test_pkg::*;

    // Parser events
    logic  accept;
    logic  hdr_valid;
    cmd_t  hdr_cmd;
    len_t  hdr_len;
    logic  pay_valid;
    byte_t pay_byte;
    cmd_t  pay_cmd;

    // Response handoff
    logic  resp_load;
    logic  resp_busy;
    len_t  resp_len;
    byte_t resp_data0;
    byte_t resp_data1;
    byte_t resp_data2;
    byte_t resp_data3;

    rx_packet_parser u_parser (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_empty_i  (rd_empty_i),
        .rd_data_i   (rd_data_i),
        .accept_i    (accept),
        .rd_en_o     (rd_en_o),
        .hdr_valid_o (hdr_valid),
        .hdr_cmd_o   (hdr_cmd),
        .hdr_len_o   (hdr_len),
        .pay_valid_o (pay_valid),
        .pay_byte_o  (pay_byte),
        .pay_cmd_o   (pay_cmd)
    );

    test_sequencer u_sequencer (
        .clk          (clk),
        .reset_i      (reset_i),
        .hdr_valid_i  (hdr_valid),
        .hdr_cmd_i    (hdr_cmd),
        .hdr_len_i    (hdr_len),
        .pay_valid_i  (pay_valid),
        .pay_byte_i   (pay_byte),
        .pay_cmd_i    (pay_cmd),
        .resp_busy_i  (resp_busy),
        .accept_o     (accept),
        .resp_load_o  (resp_load),
        .resp_len_o   (resp_len),
        .resp_data0_o (resp_data0),
        .resp_data1_o (resp_data1),
        .resp_data2_o (resp_data2),
        .resp_data3_o (resp_data3),
        .err_o        (err_o)
    );

    response_writer u_writer (
        .clk          (clk),
        .reset_i      (reset_i),
        .resp_load_i  (resp_load),
        .resp_len_i   (resp_len),
        .resp_data0_i (resp_data0),
        .resp_data1_i (resp_data1),
        .resp_data2_i (resp_data2),
        .resp_data3_i (resp_data3),
        .wr_full_i    (wr_full_i),
        .wr_afull_i   (wr_afull_i),
        .resp_busy_o  (resp_busy),
        .wr_en_o      (wr_en_o),
        .wr_data_o    (wr_data_o)
    );

endmodule

/* rtl/response_writer.sv */
// ========================================
// Response writer
// Holds one response packet and drains it
// into the output FIFO, stalling while the
// FIFO is full or almost full
// ========================================
`timescale 1ns/1ps

module response_writer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               resp_load_i,
    input  ft_test_pkg::len_t  resp_len_i,
    input  ft_test_pkg::byte_t resp_data0_i,
    input  ft_test_pkg::byte_t resp_data1_i,
    input  ft_test_pkg::byte_t resp_data2_i,
    input  ft_test_pkg::byte_t resp_data3_i,
    input  logic               wr_full_i,
    input  logic               wr_afull_i,
    output logic               resp_busy_o,
    output logic               wr_en_o,
    output ft_test_pkg::byte_t wr_data_o
);
    import ft_test_pkg::*;

    byte_t                          buf_q [RESP_BYTES];
    logic [$clog2(RESP_BYTES)-1:0]  idx_q;
    // Index of the last byte, equal to the payload length
    len_t                           last_q;
    // Last byte issued, waiting for its write edge
    logic                           last_sent_q;
    logic                           room;

    assign room = ~wr_full_i & ~wr_afull_i;

    // Packet buffer
    always_ff @(posedge clk) begin
        if (resp_load_i) begin
            buf_q[0] <= resp_data0_i;
            buf_q[1] <= resp_data1_i;
            buf_q[2] <= resp_data2_i;
            buf_q[3] <= resp_data3_i;
            last_q   <= resp_len_i;
        end
    end

    // ========================================
    // Drain control
    // ========================================
    always_ff @(posedge clk, posedge reset_i) begin
        if (reset_i) begin
            resp_busy_o <= 1'b0;
            wr_en_o     <= 1'b0;
            idx_q       <= '0;
            last_sent_q <= 1'b0;
        end else if (resp_load_i) begin
            resp_busy_o <= 1'b1;
            wr_en_o     <= 1'b0;
            idx_q       <= '0;
            last_sent_q <= 1'b0;
        end else if (resp_busy_o) begin
            if (last_sent_q) begin
                // Last byte goes into the FIFO on this edge
                resp_busy_o <= 1'b0;
                wr_en_o     <= 1'b0;
                last_sent_q <= 1'b0;
            end else if (room) begin
                wr_en_o <= 1'b1;
                if (len_t'(idx_q) == last_q) begin
                    last_sent_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end else begin
                // Hold place under back-pressure
                wr_en_o <= 1'b0;
            end
        end else begin
            wr_en_o <= 1'b0;
        end
    end

    // Output byte, qualified by wr_en_o
    always_ff @(posedge clk) begin
        if (resp_busy_o && !last_sent_q && room) begin
            wr_data_o <= buf_q[idx_q];
        end
    end

endmodule

/* rtl/test_sequencer.sv */
// ========================================
// Test sequencer
// Tracks the running test, checks headers
// and payload data, orders echo and status
// responses and halts on a failure
// ========================================
`timescale 1ns/1ps

module test_sequencer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               hdr_valid_i,
    input  ft_test_pkg::cmd_t  hdr_cmd_i,
    input  ft_test_pkg::len_t  hdr_len_i,
    input  logic               pay_valid_i,
    input  ft_test_pkg::byte_t pay_byte_i,
    input  ft_test_pkg::cmd_t  pay_cmd_i,
    input  logic               resp_busy_i,
    output logic               accept_o,
    output logic               resp_load_o,
    output ft_test_pkg::len_t  resp_len_o,
    output ft_test_pkg::byte_t resp_data0_o,
    output ft_test_pkg::byte_t resp_data1_o,
    output ft_test_pkg::byte_t resp_data2_o,
    output ft_test_pkg::byte_t resp_data3_o,
    output logic               err_o
);
    import ft_test_pkg::*;

    seq_state_t state_q;
    byte_t      test_num_q;
    byte_t      expected_q;

    // Response decided in this cycle
    logic  respond;
    logic  fail;
    cmd_t  n_cmd;
    len_t  n_len;
    byte_t n_d1;
    byte_t n_d2;
    byte_t n_d3;

    // No new byte while an event is in flight or a response pending
    assign accept_o = (state_q == SEQ_RUN) & ~hdr_valid_i & ~pay_valid_i;

    // ========================================
    // Event decode
    // ========================================
    always_comb begin
        respond = 1'b0;
        fail    = 1'b0;
        // STOPPED with one code byte unless changed below
        n_cmd   = CMD_STOPPED;
        n_len   = 6'd1;
        n_d1    = ERR_NONE;
        n_d2    = '0;
        n_d3    = '0;
        if (hdr_valid_i) begin
            case (hdr_cmd_i)
                CMD_START: begin
                    if (hdr_len_i != 6'd1) begin
                        fail = 1'b1;
                        n_d1 = ERR_START_PAYLOAD;
                    end
                end
                CMD_DATA: begin
                    // Any length, bytes checked one by one
                end
                CMD_STOP: begin
                    if (hdr_len_i == 6'd0) begin
                        respond = 1'b1;
                    end else begin
                        fail = 1'b1;
                        n_d1 = ERR_STOP_PAYLOAD;
                    end
                end
                default: begin
                    // STOPPED is a reply, not a request
                    fail = 1'b1;
                    n_d1 = ERR_INVALID_CMD;
                end
            endcase
        end else if (pay_valid_i) begin
            case (pay_cmd_i)
                CMD_START: begin
                    if (pay_byte_i != TEST_RECEIVE && pay_byte_i != TEST_LOOPBACK) begin
                        fail  = 1'b1;
                        n_len = 6'd2;
                        n_d1  = ERR_TEST_NUM;
                        n_d2  = pay_byte_i;
                    end
                end
                CMD_DATA: begin
                    if (pay_byte_i == expected_q) begin
                        // Loopback echoes each good byte
                        if (test_num_q == TEST_LOOPBACK) begin
                            respond = 1'b1;
                            n_cmd   = CMD_DATA;
                            n_d1    = pay_byte_i;
                        end
                    end else begin
                        // Received value, then expected value
                        fail  = 1'b1;
                        n_len = 6'd3;
                        n_d1  = ERR_TEST_DATA;
                        n_d2  = pay_byte_i;
                        n_d3  = expected_q;
                    end
                end
                default: begin
                    // STOP and command 3 fail at the header
                end
            endcase
        end
    end

    // ========================================
    // State, test number and data counter
    // ========================================
    always_ff @(posedge clk, posedge reset_i) begin
        if (reset_i) begin
            state_q     <= SEQ_RUN;
            test_num_q  <= TEST_RECEIVE;
            expected_q  <= '0;
            resp_load_o <= 1'b0;
            err_o       <= 1'b0;
        end else begin
            resp_load_o <= (state_q == SEQ_RUN) & (respond | fail);
            case (state_q)
                SEQ_RUN: begin
                    if (fail) begin
                        state_q <= SEQ_RESPOND_HALT;
                    end else if (respond) begin
                        state_q <= SEQ_RESPOND_RUN;
                    end
                end
                SEQ_RESPOND_RUN: begin
                    // Busy is still low in the load cycle
                    if (!resp_load_o && !resp_busy_i) begin
                        state_q <= SEQ_RUN;
                    end
                end
                SEQ_RESPOND_HALT: begin
                    if (!resp_load_o && !resp_busy_i) begin
                        state_q <= SEQ_HALTED;
                    end
                end
                default: begin
                    // Halted until reset
                end
            endcase
            // Failure wins over the START clear
            if (fail) begin
                err_o <= 1'b1;
            end else if (hdr_valid_i && hdr_cmd_i == CMD_START) begin
                err_o <= 1'b0;
            end
            if (pay_valid_i && pay_cmd_i == CMD_START) begin
                test_num_q <= pay_byte_i;
                expected_q <= '0;
            end else if (pay_valid_i && pay_cmd_i == CMD_DATA && !fail) begin
                expected_q <= expected_q + 8'd1;
            end
        end
    end

    // Response packet
    always_ff @(posedge clk) begin
        if (respond || fail) begin
            resp_len_o   <= n_len;
            resp_data0_o <= {n_cmd, n_len};
            resp_data1_o <= n_d1;
            resp_data2_o <= n_d2;
            resp_data3_o <= n_d3;
        end
    end

endmodule

/* rtl/rx_packet_parser.sv */
// ========================================
// Input packet parser
// Reads the input FIFO one byte at a time
// and splits the stream into header and
// payload events for the sequencer
// ========================================
`timescale 1ns/1ps

module rx_packet_parser (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               rd_empty_i,
    input  ft_test_pkg::byte_t rd_data_i,
    input  logic               accept_i,
    output logic               rd_en_o,
    output logic               hdr_valid_o,
    output ft_test_pkg::cmd_t  hdr_cmd_o,
    output ft_test_pkg::len_t  hdr_len_o,
    output logic               pay_valid_o,
    output ft_test_pkg::byte_t pay_byte_o,
    output ft_test_pkg::cmd_t  pay_cmd_o
);
    import ft_test_pkg::*;

    // Byte taken on the previous edge
    logic  taken_q;
    byte_t byte_q;

    // Framing state
    logic  in_payload_q;
    len_t  remain_q;
    cmd_t  cmd_q;

    // Read only when data is there, the sequencer agrees,
    // and the last byte has been handed on
    assign rd_en_o = ~rd_empty_i & accept_i & ~taken_q;

    // ========================================
    // Byte capture
    // ========================================
    always_ff @(posedge clk, posedge reset_i) begin
        if (reset_i) begin
            taken_q <= 1'b0;
        end else begin
            taken_q <= rd_en_o;
        end
    end

    // FWFT head byte, qualified by taken_q
    always_ff @(posedge clk) begin
        if (rd_en_o) begin
            byte_q <= rd_data_i;
        end
    end

    // ========================================
    // Header and payload framing
    // ========================================
    always_ff @(posedge clk, posedge reset_i) begin
        if (reset_i) begin
            in_payload_q <= 1'b0;
            remain_q     <= '0;
            cmd_q        <= CMD_START;
        end else if (taken_q) begin
            if (!in_payload_q) begin
                // Zero length header stays in header mode
                if (byte_q[5:0] != 6'd0) begin
                    in_payload_q <= 1'b1;
                    remain_q     <= byte_q[5:0];
                    cmd_q        <= byte_q[7:6];
                end
            end else begin
                remain_q <= remain_q - 6'd1;
                // Last payload byte of the packet
                if (remain_q == 6'd1) begin
                    in_payload_q <= 1'b0;
                end
            end
        end
    end

    // Events, one cycle after the take edge
    assign hdr_valid_o = taken_q & ~in_payload_q;
    assign hdr_cmd_o   = byte_q[7:6];
    assign hdr_len_o   = byte_q[5:0];
    assign pay_valid_o = taken_q & in_payload_q;
    assign pay_byte_o  = byte_q;
    assign pay_cmd_o   = cmd_q;

endmodule

/* rtl/ft_test_pkg.sv */
// ========================================
// FT test controller shared definitions
// Packet commands, test numbers, error
// codes, byte types and sequencer states
// ========================================

package ft_test_pkg;

    // Basic widths
    typedef logic [7:0] byte_t;
    typedef logic [1:0] cmd_t;
    typedef logic [5:0] len_t;

    // ========================================
    // Packet commands, header bits 7..6
    // ========================================
    localparam cmd_t CMD_START   = 2'd0;
    localparam cmd_t CMD_DATA    = 2'd1;
    localparam cmd_t CMD_STOP    = 2'd2;
    // Reply only, never valid on input
    localparam cmd_t CMD_STOPPED = 2'd3;

    // Test numbers carried by the START payload
    localparam byte_t TEST_RECEIVE  = 8'd0;
    localparam byte_t TEST_LOOPBACK = 8'd1;

    // ========================================
    // Error codes in STOPPED payload byte 0
    // ========================================
    localparam byte_t ERR_NONE          = 8'd0;
    localparam byte_t ERR_INVALID_CMD   = 8'd1;
    localparam byte_t ERR_START_PAYLOAD = 8'd2;
    localparam byte_t ERR_STOP_PAYLOAD  = 8'd3;
    localparam byte_t ERR_TEST_NUM      = 8'd4;
    localparam byte_t ERR_TEST_DATA     = 8'd5;

    // Response buffer depth, header plus 3 payload bytes
    localparam int RESP_BYTES = 4;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_RUN,
        SEQ_RESPOND_RUN,
        SEQ_RESPOND_HALT,
        SEQ_HALTED
    } seq_state_t;

endpackage
